// File: project.f
design/rv_m_pkg.sv
design/mdu_types_pkg.sv
design/mul_unit.sv
design/div_unit.sv
design/mdu.sv
sim/mdu_asserts.sv
sim/mdu_tb.sv

// File: sim/mdu_tb.sv
`timescale 1ns/1ps

module mdu_tb;

    import rv_m_pkg::*;

    localparam int MUL_LATENCY = 3;
    localparam int TIMEOUT     = 100;                 // cycles per stall wait
    localparam int N_RANDOM    = 24;

    typedef struct packed {
        mdu_op_e op;
        word_t   a;
        word_t   b;
        word_t   exp;                                 // expected result_o
    } entry_t;

    logic    clk_i;
    logic    rst_i;
    logic    ex_en_i;
    logic    en_i;
    mdu_op_e mdu_op_i;
    word_t   a1_i;
    word_t   a2_i;
    word_t   result_o;
    logic    mul_stall_o;
    logic    div_stall_o;

    entry_t  table_q[$];

    mdu #(
        .MUL_LATENCY (MUL_LATENCY)
    ) dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ex_en_i     (ex_en_i),
        .en_i        (en_i),
        .mdu_op_i    (mdu_op_i),
        .a1_i        (a1_i),
        .a2_i        (a2_i),
        .result_o    (result_o),
        .mul_stall_o (mul_stall_o),
        .div_stall_o (div_stall_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ##################################################
    // reference model and helpers
    // ##################################################

    function automatic word_t ref_result(input mdu_op_e op, input word_t a, input word_t b);
        longint      sa;
        longint      sb;
        longint      ub;
        logic [63:0] p_ss;
        logic [63:0] p_su;
        logic [63:0] p_uu;
        logic        ovf;
        sa   = longint'($signed(a));
        sb   = longint'($signed(b));
        ub   = longint'({32'h0, b});
        p_ss = sa * sb;                               // signed x signed
        p_su = sa * ub;                               // signed x unsigned
        p_uu = {32'h0, a} * {32'h0, b};
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);   // signed overflow
        case (op)
            MUL_OP:    return p_ss[31:0];
            MULH_OP:   return p_ss[63:32];
            MULHSU_OP: return p_su[63:32];
            MULHU_OP:  return p_uu[63:32];
            DIV_OP:    return (b == 0) ? 32'hffff_ffff : ovf ? a : word_t'(sa / sb);
            REM_OP:    return (b == 0) ? a : ovf ? 32'h0 : word_t'(sa % sb);
            DIVU_OP:   return (b == 0) ? 32'hffff_ffff : a / b;
            default:   return (b == 0) ? a : a % b;                    // remu
        endcase
    endfunction

    // cycles the stall stays high, counted from the request cycle
    function automatic int stall_cycles_of(input entry_t e);
        if (!e.op[2]) return MUL_LATENCY;
        if (e.b == 0) return 1;
        if ((e.op == DIV_OP || e.op == REM_OP) && e.a == 32'h8000_0000 && e.b == '1) return 1;
        return 33;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            fail_run($sformatf("ERR %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        assert (got == exp) else begin
            fail_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic add_entry(input mdu_op_e op, input word_t a, input word_t b, input word_t exp);
        table_q.push_back('{op: op, a: a, b: b, exp: exp});
    endtask

    task automatic run_entry(input entry_t e);
        int    cycles;
        string stall_name;
        stall_name = e.op[2] ? "div_stall_o" : "mul_stall_o";
        @(posedge clk_i);
        ex_en_i  <= 1'b1;
        en_i     <= 1'b1;
        mdu_op_i <= e.op;
        a1_i     <= e.a;
        a2_i     <= e.b;
        cycles   = 0;
        @(negedge clk_i);
        while (e.op[2] ? div_stall_o : mul_stall_o) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run($sformatf("timeout, %s still high after %0d cycles", stall_name, TIMEOUT));
            end
            @(negedge clk_i);
        end
        check_word("result_o", result_o, e.exp);     // done cycle, combinational path
        check_count({stall_name, " cycles"}, cycles, stall_cycles_of(e));
        @(posedge clk_i);
        en_i     <= 1'b0;                             // idle with junk operands
        mdu_op_i <= mdu_op_e'($urandom() % 8);
        a1_i     <= $urandom();
        a2_i     <= $urandom();
        repeat (2) begin
            @(negedge clk_i);
            check_word("result_o", result_o, e.exp); // held from the register
        end
    endtask

    // ##################################################
    // stimulus
    // ##################################################

    initial begin
        entry_t e;
        void'($urandom(17864));
        rst_i    = 1'b1;
        ex_en_i  = 1'b0;
        en_i     = 1'b0;
        mdu_op_i = MUL_OP;
        a1_i     = '0;
        a2_i     = '0;

        // multiplies
        add_entry(MUL_OP,    32'hffff_fffe, 32'h0000_0003, 32'hffff_fffa);
        add_entry(MULH_OP,   32'hffff_fffe, 32'h0000_0003, 32'hffff_ffff);
        add_entry(MULHSU_OP, 32'hffff_fffe, 32'hffff_ffff, 32'hffff_fffe);
        add_entry(MULHU_OP,  32'hffff_fffe, 32'hffff_ffff, 32'hffff_fffd);
        add_entry(MUL_OP,    32'h8000_0000, 32'h8000_0000, 32'h0000_0000);
        add_entry(MULH_OP,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        add_entry(MULHSU_OP, 32'h8000_0000, 32'h8000_0000, 32'hc000_0000);
        add_entry(MULHU_OP,  32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        add_entry(MULH_OP,   32'h7fff_ffff, 32'h8000_0000, 32'hc000_0000);
        // divides, all sign mixes of 20 and 6
        add_entry(DIV_OP,    32'h0000_0014, 32'h0000_0006, 32'h0000_0003);
        add_entry(REM_OP,    32'h0000_0014, 32'h0000_0006, 32'h0000_0002);
        add_entry(DIV_OP,    32'hffff_ffec, 32'h0000_0006, 32'hffff_fffd);
        add_entry(REM_OP,    32'hffff_ffec, 32'h0000_0006, 32'hffff_fffe);
        add_entry(DIV_OP,    32'h0000_0014, 32'hffff_fffa, 32'hffff_fffd);
        add_entry(REM_OP,    32'h0000_0014, 32'hffff_fffa, 32'h0000_0002);
        add_entry(DIV_OP,    32'hffff_ffec, 32'hffff_fffa, 32'h0000_0003);
        add_entry(REM_OP,    32'hffff_ffec, 32'hffff_fffa, 32'hffff_fffe);
        add_entry(DIVU_OP,   32'hffff_ffec, 32'h0000_0006, 32'h2aaa_aaa7);
        add_entry(REMU_OP,   32'hffff_ffec, 32'h0000_0006, 32'h0000_0002);
        add_entry(DIVU_OP,   32'h0000_0014, 32'hffff_fffa, 32'h0000_0000);
        add_entry(REMU_OP,   32'h0000_0014, 32'hffff_fffa, 32'h0000_0014);
        add_entry(DIV_OP,    32'h0000_0005, 32'h0000_0007, 32'h0000_0000);
        add_entry(REM_OP,    32'h0000_0005, 32'h0000_0007, 32'h0000_0005);
        add_entry(DIVU_OP,   32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
        add_entry(REMU_OP,   32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        // isa corner cases, one cycle stall
        add_entry(DIV_OP,    32'h1234_5678, 32'h0000_0000, 32'hffff_ffff);
        add_entry(REM_OP,    32'h1234_5678, 32'h0000_0000, 32'h1234_5678);
        add_entry(DIVU_OP,   32'h1234_5678, 32'h0000_0000, 32'hffff_ffff);
        add_entry(REMU_OP,   32'h1234_5678, 32'h0000_0000, 32'h1234_5678);
        add_entry(DIV_OP,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        add_entry(REM_OP,    32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);

        for (int i = 0; i < N_RANDOM; i++) begin
            e.op = mdu_op_e'($urandom() % 8);
            e.a  = $urandom();
            e.b  = ($urandom() % 4 == 0) ? word_t'($urandom() % 16) : word_t'($urandom());
            e.exp = ref_result(e.op, e.a, e.b);
            table_q.push_back(e);
        end

        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_word("mul_stall_o", {31'b0, mul_stall_o}, '0);
        check_word("div_stall_o", {31'b0, div_stall_o}, '0);
        check_word("result_o", result_o, '0);

        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// File: sim/mdu_asserts.sv
`timescale 1ns/1ps

module mdu_asserts #(
    parameter int MUL_LATENCY = 2
) (
    input logic                     clk_i,
    input logic                     rst_i,
    input logic                     mul_start_i,
    input logic                     mul_stall_i,
    input logic                     div_stall_i,
    input logic                     div_done_i,
    input mdu_types_pkg::div_state_e div_state_i
);

    import mdu_types_pkg::*;

    // ##################################################
    // stall behavior
    // ##################################################

    // a multiply never waits while the divider is still working
    no_double_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        mul_stall_i |-> (div_state_i == DIV_IDLE))
        else $error("multiply stall high while the divider is busy");

    stall_low_after_reset: assert property (@(posedge clk_i)
        $fell(rst_i) |-> (!mul_stall_i && !div_stall_i && div_state_i == DIV_IDLE))
        else $error("stall high or divider busy right after reset");

    mul_release: assert property (@(posedge clk_i) disable iff (rst_i)
        mul_start_i |-> ##[1:MUL_LATENCY] !mul_stall_i)
        else $error("multiply stall held longer than the pipeline depth");

    // ##################################################
    // divider done
    // ##################################################

    div_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        div_done_i |=> !div_done_i)
        else $error("divider done longer than one cycle");

endmodule

bind mdu mdu_asserts #(
    .MUL_LATENCY (MUL_LATENCY)
) u_mdu_asserts (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mul_start_i (mul_start),
    .mul_stall_i (mul_stall_o),
    .div_stall_i (div_stall_o),
    .div_done_i  (div_done),
    .div_state_i (u_div_unit.state_q)
);

// File: design/mdu.sv
`timescale 1ns/1ps

module mdu #(
    parameter int MUL_LATENCY = 2                     // multiplier stages, 1 to 4
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              ex_en_i,
    input  logic              en_i,
    input  rv_m_pkg::mdu_op_e mdu_op_i,
    input  rv_m_pkg::word_t   a1_i,
    input  rv_m_pkg::word_t   a2_i,
    output rv_m_pkg::word_t   result_o,
    output logic              mul_stall_o,
    output logic              div_stall_o
);

    import rv_m_pkg::*;
    import mdu_types_pkg::*;

    mdu_req_t req;
    logic     mul_req;
    logic     div_req;
    logic     mul_start;
    logic     div_start;
    logic     mul_wait_q;                             // multiply in flight
    logic     div_wait_q;                             // divide in flight

    dword_t   mul_product;
    logic     mul_done;
    div_res_t div_res;
    logic     div_done;

    word_t    sel_res;
    word_t    result_q;

    // ##################################################
    // request decode and start pulses
    // ##################################################

    assign req     = '{op: mdu_op_i, a: a1_i, b: a2_i};
    assign mul_req = ex_en_i & en_i & ~req.op[2];
    assign div_req = ex_en_i & en_i & req.op[2];

    assign mul_start = mul_req & ~mul_wait_q;         // first cycle of the request
    assign div_start = div_req & ~div_wait_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mul_wait_q <= 1'b0;
            div_wait_q <= 1'b0;
        end else begin
            if (mul_done) mul_wait_q <= 1'b0;
            else if (mul_start) mul_wait_q <= 1'b1;
            if (div_done) div_wait_q <= 1'b0;
            else if (div_start) div_wait_q <= 1'b1;
        end
    end

    mul_unit #(
        .MUL_LATENCY (MUL_LATENCY)
    ) u_mul_unit (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start_i   (mul_start),
        .req_i     (req),
        .product_o (mul_product),
        .done_o    (mul_done)
    );

    div_unit u_div_unit (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (div_start),
        .req_i   (req),
        .res_o   (div_res),
        .done_o  (div_done)
    );

    // stall drops in the done cycle itself
    assign mul_stall_o = mul_req & ~mul_done;
    assign div_stall_o = div_req & ~div_done;

    // ##################################################
    // result select and hold
    // ##################################################

    always_comb begin
        unique case (req.op)
            MUL_OP:                       sel_res = mul_product[31:0];
            MULH_OP, MULHSU_OP, MULHU_OP: sel_res = mul_product[63:32];
            DIV_OP, DIVU_OP:              sel_res = div_res.quotient;
            default:                      sel_res = div_res.remainder;   // rem, remu
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_q <= '0;
        end else if (mul_done | div_done) begin
            result_q <= sel_res;
        end
    end

    assign result_o = (mul_done | div_done) ? sel_res : result_q;

endmodule

// File: design/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  mdu_types_pkg::mdu_req_t req_i,
    output mdu_types_pkg::div_res_t res_o,
    output logic                    done_o
);

    import rv_m_pkg::*;
    import mdu_types_pkg::*;

    div_state_e state_q;
    div_cnt_t   cnt_q;

    word_t quo_q;                                     // dividend in, quotient out
    word_t rem_q;                                     // partial remainder
    word_t dvsr_q;                                    // divisor magnitude
    logic  neg_quo_q;
    logic  neg_rem_q;

    logic  signed_op;
    logic  a_neg;
    logic  b_neg;
    word_t a_mag;
    word_t b_mag;
    logic  div_zero;
    logic  overflow;
    logic  accept;

    logic [32:0] rem_shift;
    logic [32:0] diff;

    // ##################################################
    // operand decode
    // ##################################################

    assign signed_op = (req_i.op == DIV_OP) || (req_i.op == REM_OP);
    assign a_neg     = signed_op & req_i.a[31];
    assign b_neg     = signed_op & req_i.b[31];
    assign a_mag     = a_neg ? -req_i.a : req_i.a;   // most negative stays 2^31
    assign b_mag     = b_neg ? -req_i.b : req_i.b;

    assign div_zero  = (req_i.b == '0);
    assign overflow  = signed_op && (req_i.a == 32'h8000_0000) && (req_i.b == '1);
    assign accept    = start_i && (state_q == DIV_IDLE);   // busy unit drops starts

    // one restoring step
    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = rem_shift - {1'b0, dvsr_q};

    // ##################################################
    // control
    // ##################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            unique case (state_q)
                DIV_IDLE: begin
                    if (accept) begin
                        state_q <= (div_zero || overflow) ? DIV_DONE : DIV_RUN;
                        cnt_q   <= '0;
                    end
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == div_cnt_t'(DIV_STEPS - 1)) begin
                        state_q <= DIV_DONE;
                    end
                end
                DIV_DONE: state_q <= DIV_IDLE;
                default:  state_q <= DIV_IDLE;
            endcase
        end
    end

    // ##################################################
    // datapath
    // ##################################################

    always_ff @(posedge clk_i) begin
        if (accept) begin
            if (div_zero) begin
                quo_q     <= '1;                      // isa result, no iteration
                rem_q     <= req_i.a;
                neg_quo_q <= 1'b0;
                neg_rem_q <= 1'b0;
            end else if (overflow) begin
                quo_q     <= req_i.a;
                rem_q     <= '0;
                neg_quo_q <= 1'b0;
                neg_rem_q <= 1'b0;
            end else begin
                quo_q     <= a_mag;
                rem_q     <= '0;
                dvsr_q    <= b_mag;
                neg_quo_q <= a_neg ^ b_neg;
                neg_rem_q <= a_neg;                   // remainder follows the dividend
            end
        end else if (state_q == DIV_RUN) begin
            quo_q <= {quo_q[30:0], ~diff[32]};
            rem_q <= diff[32] ? rem_shift[31:0] : diff[31:0];  // restore on borrow
        end
    end

    assign res_o.quotient  = neg_quo_q ? -quo_q : quo_q;
    assign res_o.remainder = neg_rem_q ? -rem_q : rem_q;
    assign done_o          = (state_q == DIV_DONE);

endmodule

// File: design/mul_unit.sv
`timescale 1ns/1ps

module mul_unit #(
    parameter int MUL_LATENCY = 2                     // pipeline stages, 1 to 4
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  mdu_types_pkg::mdu_req_t req_i,
    output rv_m_pkg::dword_t        product_o,
    output logic                    done_o
);

    import rv_m_pkg::*;

    logic signed [32:0] a_ext;                        // operand a, 33-bit two's complement
    logic signed [32:0] b_ext;
    logic signed [65:0] prod_full;

    dword_t                 prod_q [MUL_LATENCY];     // product per stage
    logic [MUL_LATENCY-1:0] vld_q;                    // valid per stage

    // ##################################################
    // operand extension
    // ##################################################

    // a 33-bit signed multiply covers all three sign mixes
    always_comb begin
        unique case (req_i.op)
            MULH_OP: begin
                a_ext = {req_i.a[31], req_i.a};
                b_ext = {req_i.b[31], req_i.b};
            end
            MULHSU_OP: begin
                a_ext = {req_i.a[31], req_i.a};
                b_ext = {1'b0, req_i.b};
            end
            default: begin                            // mul, mulhu
                a_ext = {1'b0, req_i.a};
                b_ext = {1'b0, req_i.b};
            end
        endcase
    end

    assign prod_full = a_ext * b_ext;                 // top two bits are sign copies

    // ##################################################
    // product pipeline
    // ##################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= start_i;
            for (int i = 1; i < MUL_LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            prod_q[0] <= prod_full[63:0];             // truncate to 64 bits
        end
        for (int i = 1; i < MUL_LATENCY; i++) begin
            if (vld_q[i-1]) begin
                prod_q[i] <= prod_q[i-1];             // each stage moves independently
            end
        end
    end

    assign product_o = prod_q[MUL_LATENCY-1];
    assign done_o    = vld_q[MUL_LATENCY-1];

endmodule

// File: design/mdu_types_pkg.sv
package mdu_types_pkg;

    import rv_m_pkg::*;

    // ##################################################
    // unit interfaces
    // ##################################################

    typedef struct packed {
        mdu_op_e op;                                  // funct3 of the instruction
        word_t   a;                                   // rs1 value, dividend
        word_t   b;                                   // rs2 value, divisor
    } mdu_req_t;

    typedef struct packed {
        word_t quotient;
        word_t remainder;
    } div_res_t;

    // ##################################################
    // divider control
    // ##################################################

    localparam int DIV_STEPS = 32;                    // one quotient bit per step

    typedef logic [$clog2(DIV_STEPS)-1:0] div_cnt_t;  // step counter

    typedef enum logic [1:0] {
        DIV_IDLE,                                     // waiting for start
        DIV_RUN,                                      // shift-subtract steps
        DIV_DONE                                      // sign fixup, done pulse
    } div_state_e;

endpackage

// File: design/rv_m_pkg.sv
package rv_m_pkg;

    // ##################################################
    // register widths
    // ##################################################

    localparam int XLEN = 32;                         // rv32 register width

    typedef logic [XLEN-1:0]   word_t;                // one register value
    typedef logic [2*XLEN-1:0] dword_t;               // full multiplier product

    // ##################################################
    // m-extension funct3 encodings
    // ##################################################

    // bit 2 splits the multiplies from the divides
    typedef enum logic [2:0] {
        MUL_OP    = 3'b000,                           // low word, any sign
        MULH_OP   = 3'b001,                           // high word, signed x signed
        MULHSU_OP = 3'b010,                           // high word, signed x unsigned
        MULHU_OP  = 3'b011,                           // high word, unsigned x unsigned
        DIV_OP    = 3'b100,                           // signed quotient
        DIVU_OP   = 3'b101,                           // unsigned quotient
        REM_OP    = 3'b110,                           // signed remainder
        REMU_OP   = 3'b111                            // unsigned remainder
    } mdu_op_e;

endpackage
